// ==== files.f ====
verilog/mem_pkg.sv
verilog/fetch_port.sv
verilog/exe_port.sv
verilog/ram_arbiter.sv
verilog/sram_ctrl.sv
verilog/mem_unit.sv
verif/sram_model.sv
verif/mem_unit_checker.sv
verif/tb_mem_unit.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_mem_unit
FILELIST  = files.f
OBJ_DIR   = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf $(OBJ_DIR)

// ==== verif/tb_mem_unit.sv ====
`default_nettype none

module tb_mem_unit;

	timeunit 1ns;
	timeprecision 100ps;

	localparam int RAM_WAIT = 2;
	localparam int TAG_W    = 8;
	// Cycle budget of each wait loop
	localparam int LIMIT    = 200;
	localparam logic [mem_pkg::ADDR_W-1:0] CODE_BASE = 16'h0800;
	localparam logic [mem_pkg::ADDR_W-1:0] SB_BASE   = 16'h0200;

	logic                       clk;
	logic                       rst;
	logic                       fetch_req;
	logic [mem_pkg::ADDR_W-1:0] fetch_addr;
	logic                       fetch_done;
	logic [mem_pkg::DATA_W-1:0] fetch_data;
	logic                       exe_req;
	logic                       exe_write;
	logic [mem_pkg::ADDR_W-1:0] exe_addr;
	logic [mem_pkg::DATA_W-1:0] exe_wdata;
	logic [TAG_W-1:0]           exe_tag;
	logic                       exe_done;
	logic [mem_pkg::DATA_W-1:0] exe_rdata;
	logic [mem_pkg::ADDR_W-1:0] ram_addr;
	wire  [mem_pkg::DATA_W-1:0] ram_data;
	logic                       ram_oe_n;
	logic                       ram_we_n;
	logic                       ram_en_n;

	int errors;
	int checks;
	int tests;
	int last_errors;

	// Expected contents of the load/store region
	logic [mem_pkg::DATA_W-1:0] sb [16];

	mem_unit #(
		.RAM_WAIT (RAM_WAIT),
		.TAG_W    (TAG_W)
	) uut (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_done (fetch_done),
		.fetch_data (fetch_data),
		.exe_req    (exe_req),
		.exe_write  (exe_write),
		.exe_addr   (exe_addr),
		.exe_wdata  (exe_wdata),
		.exe_tag    (exe_tag),
		.exe_done   (exe_done),
		.exe_rdata  (exe_rdata),
		.ram_addr   (ram_addr),
		.ram_data   (ram_data),
		.ram_oe_n   (ram_oe_n),
		.ram_we_n   (ram_we_n),
		.ram_en_n   (ram_en_n)
	);

	sram_model u_sram (
		.addr (ram_addr),
		.data (ram_data),
		.oe_n (ram_oe_n),
		.we_n (ram_we_n),
		.en_n (ram_en_n)
	);

	bind mem_unit mem_unit_checker #(
		.RAM_WAIT (RAM_WAIT)
	) u_checker (
		.clk       (clk),
		.rst       (rst),
		.ram_oe_n  (ram_oe_n),
		.ram_we_n  (ram_we_n),
		.ram_en_n  (ram_en_n),
		.bus_drive (u_sram_ctrl.drive),
		.write_q   (u_sram_ctrl.write_q),
		.exe_need  (exe_need),
		.busy      (busy),
		.start     (start),
		.exe_done  (exe_done)
	);

	always #5 clk = ~clk;

	////////////////////
	// Helpers
	////////////////////

	// Instruction words placed in the code region
	function automatic logic [mem_pkg::DATA_W-1:0] code_word(input logic [15:0] a);
		return {a[7:0], a[15:8]} ^ 16'h5a3c;
	endfunction

	task automatic check_equal(input string name, input logic [31:0] got,
			input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h", name, got, exp);
		end
	endtask

	task automatic abort_on_timeout(input string what);
		$display("ERROR: no %s within %0d cycles, run stopped", what, LIMIT);
		$display("TEST FAIL");
		$finish;
	endtask

	task automatic close_test(input string name);
		tests++;
		$display("%-16s %s (%0d errors)", name,
			(errors == last_errors) ? "ok" : "failed", errors - last_errors);
		last_errors = errors;
	endtask

	// One load or store with cycles counted from the arbiter's sampling edge
	task automatic exe_access(input logic write, input logic [15:0] a,
			input logic [15:0] wdata, output int cycles);
		int n;
		int strobe;
		n = 0;
		strobe = 0;
		@(posedge clk);
		exe_req   <= 1'b1;
		exe_write <= write;
		exe_addr  <= a;
		exe_wdata <= wdata;
		exe_tag   <= exe_tag + 1'b1;
		@(negedge clk);
		while (!exe_done && n < LIMIT) begin
			@(posedge clk);
			n++;
			@(negedge clk);
			// Only this access runs, so the pins carry its address
			if (!ram_en_n) begin
				check_equal("ram_addr", 32'(ram_addr), 32'(a));
			end
			if (write ? !ram_we_n : !ram_oe_n) begin
				strobe++;
			end
		end
		if (!exe_done) begin
			abort_on_timeout("exe_done");
		end
		if (write) begin
			check_equal("ram_we_n low cycles", 32'(strobe), 32'(1 + RAM_WAIT));
		end else begin
			check_equal("ram_oe_n low cycles", 32'(strobe), 32'(1 + RAM_WAIT));
		end
		cycles = n - 1;
	endtask

	task automatic fetch_word(input logic [15:0] a);
		int n;
		n = 0;
		@(posedge clk);
		fetch_req  <= 1'b1;
		fetch_addr <= a;
		@(negedge clk);
		while (!fetch_done && n < LIMIT) begin
			@(posedge clk);
			n++;
			@(negedge clk);
		end
		if (!fetch_done) begin
			abort_on_timeout("fetch_done");
		end
	endtask

	////////////////////
	// Directed tests
	////////////////////

	task automatic reset_state();
		@(negedge clk);
		check_equal("ram_oe_n", 32'(ram_oe_n), 32'd1);
		check_equal("ram_we_n", 32'(ram_we_n), 32'd1);
		check_equal("ram_en_n", 32'(ram_en_n), 32'd1);
		check_equal("fetch_done", 32'(fetch_done), 32'd0);
		close_test("reset_state");
	endtask

	task automatic write_then_read();
		int cycles;
		logic [15:0] value;
		value = 16'($urandom);
		exe_access(1'b1, 16'h0040, value, cycles);
		check_equal("write latency", 32'(cycles), 32'(4 + RAM_WAIT));
		exe_access(1'b0, 16'h0040, 16'h0000, cycles);
		check_equal("read latency", 32'(cycles), 32'(4 + RAM_WAIT));
		check_equal("exe_rdata", 32'(exe_rdata), 32'(value));
		close_test("write_then_read");
	endtask

	task automatic fetch_reuse();
		int oe_low;
		oe_low = 0;
		fetch_word(CODE_BASE + 16'd5);
		check_equal("fetch_data", 32'(fetch_data), 32'(code_word(CODE_BASE + 16'd5)));
		// With the same address held no new SRAM read may start
		repeat (20) begin
			@(posedge clk);
			@(negedge clk);
			if (!ram_oe_n) begin
				oe_low++;
			end
		end
		check_equal("ram_oe_n low cycles", 32'(oe_low), 32'd0);
		check_equal("fetch_done", 32'(fetch_done), 32'd1);
		close_test("fetch_reuse");
	endtask

	task automatic same_edge_race();
		int n;
		logic exe_seen;
		logic fetch_at_exe;
		n = 0;
		exe_seen = 1'b0;
		fetch_at_exe = 1'b1;
		@(posedge clk);
		exe_req    <= 1'b1;
		exe_write  <= 1'b0;
		exe_addr   <= CODE_BASE + 16'd1;
		exe_tag    <= exe_tag + 1'b1;
		fetch_req  <= 1'b1;
		fetch_addr <= CODE_BASE + 16'd2;
		@(negedge clk);
		while (!(exe_done && fetch_done) && n < LIMIT) begin
			@(posedge clk);
			n++;
			@(negedge clk);
			if (exe_done && !exe_seen) begin
				exe_seen = 1'b1;
				fetch_at_exe = fetch_done;
			end
		end
		if (!(exe_done && fetch_done)) begin
			abort_on_timeout("completion of both ports");
		end
		check_equal("fetch_done", 32'(fetch_at_exe), 32'd0);
		check_equal("exe_rdata", 32'(exe_rdata), 32'(code_word(CODE_BASE + 16'd1)));
		check_equal("fetch_data", 32'(fetch_data), 32'(code_word(CODE_BASE + 16'd2)));
		close_test("same_edge_race");
	endtask

	task automatic random_traffic();
		int cycles;
		int idx;
		logic [15:0] value;
		logic [15:0] a;
		for (int i = 0; i < 32; i++) begin
			idx = int'($urandom_range(15, 0));
			if ($urandom_range(1, 0) == 1) begin
				value = 16'($urandom);
				exe_access(1'b1, SB_BASE + 16'(idx), value, cycles);
				sb[idx] = value;
			end else begin
				exe_access(1'b0, SB_BASE + 16'(idx), 16'h0000, cycles);
				check_equal("exe_rdata", 32'(exe_rdata), 32'(sb[idx]));
			end
			check_equal("exe latency", 32'(cycles), 32'(4 + RAM_WAIT));
			if (i % 2 == 1) begin
				a = CODE_BASE + 16'(i / 2);
				fetch_word(a);
				check_equal("fetch_data", 32'(fetch_data), 32'(code_word(a)));
			end
		end
		close_test("random_traffic");
	endtask

	////////////////////
	// Main sequence
	////////////////////

	initial begin
		void'($urandom(32'h3258_2748));
		clk        = 1'b0;
		rst        = 1'b0;
		fetch_req  = 1'b0;
		fetch_addr = '0;
		exe_req    = 1'b0;
		exe_write  = 1'b0;
		exe_addr   = '0;
		exe_wdata  = '0;
		exe_tag    = '0;
		errors      = 0;
		checks      = 0;
		tests       = 0;
		last_errors = 0;
		repeat (16) @(posedge clk);
		rst <= 1'b1;
		// Code words and the scoreboard region loaded through the backdoor
		for (int i = 0; i < 16; i++) begin
			u_sram.preload(CODE_BASE + 16'(i), code_word(CODE_BASE + 16'(i)));
			sb[i] = 16'($urandom);
			u_sram.preload(SB_BASE + 16'(i), sb[i]);
		end
		reset_state();
		write_then_read();
		fetch_reuse();
		same_edge_race();
		random_traffic();
		$display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
		if (errors == 0) begin
			$display("TEST PASS");
		end else begin
			$display("TEST FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verif/mem_unit_checker.sv ====
`default_nettype none

module mem_unit_checker #(
	parameter int RAM_WAIT = 0
) (
	input wire clk,
	input wire rst,
	input wire ram_oe_n,
	input wire ram_we_n,
	input wire ram_en_n,
	input wire bus_drive,
	input wire write_q,
	input wire exe_need,
	input wire busy,
	input wire start,
	input wire exe_done
);

	timeunit 1ns;
	timeprecision 100ps;

	////////////////////
	// Strobes and bus
	////////////////////

	strobe_exclusive: assert property (@(posedge clk) disable iff (!rst)
		!(!ram_oe_n && !ram_we_n))
		else $error("read and write strobes are low together");

	// Controller drives only inside an enabled write, never against a read
	bus_in_write: assert property (@(posedge clk) disable iff (!rst)
		bus_drive |-> (!ram_en_n && ram_oe_n && write_q))
		else $error("data bus driven outside a write access");

	we_has_data: assert property (@(posedge clk) disable iff (!rst)
		!ram_we_n |-> bus_drive)
		else $error("write strobe low while the bus is released");

	////////////////////
	// Latency
	////////////////////

	// Uncontested load or store, done level shows 4+RAM_WAIT edges after sampling
	exe_latency: assert property (@(posedge clk) disable iff (!rst)
		(exe_need && !busy && !start) |-> ##(5 + RAM_WAIT) $rose(exe_done))
		else $error("execute access finished with the wrong latency");

endmodule

`default_nettype wire

// ==== verif/sram_model.sv ====
`default_nettype none

module sram_model (
	input  wire [mem_pkg::ADDR_W-1:0] addr,
	inout  wire [mem_pkg::DATA_W-1:0] data,
	input  wire                       oe_n,
	input  wire                       we_n,
	input  wire                       en_n
);

	timeunit 1ns;
	timeprecision 100ps;

	// Full 64K word array
	logic [mem_pkg::DATA_W-1:0] mem [0:(1 << mem_pkg::ADDR_W) - 1];

	////////////////////
	// Read path
	////////////////////

	// Chip drives the bus only for an enabled read strobe
	assign data = (!en_n && !oe_n && we_n) ? mem[addr] : 'z;

	////////////////////
	// Write path
	////////////////////

	// Data is taken on the trailing edge of the write strobe
	always @(posedge we_n) begin
		if (!en_n) begin
			mem[addr] = data;
		end
	end

	// Backdoor load, no bus cycle
	task automatic preload(input logic [mem_pkg::ADDR_W-1:0] a,
			input logic [mem_pkg::DATA_W-1:0] value);
		mem[a] = value;
	endtask

endmodule

`default_nettype wire

// ==== verilog/mem_unit.sv ====
`default_nettype none

module mem_unit #(
	parameter int RAM_WAIT = 0,
	parameter int TAG_W    = 8
) (
	input  wire                            clk,
	input  wire                            rst,

	// Instruction fetch
	input  wire                            fetch_req,
	input  wire  [mem_pkg::ADDR_W-1:0]     fetch_addr,
	output logic                           fetch_done,
	output logic [mem_pkg::DATA_W-1:0]     fetch_data,

	// Load/store
	input  wire                            exe_req,
	input  wire                            exe_write,
	input  wire  [mem_pkg::ADDR_W-1:0]     exe_addr,
	input  wire  [mem_pkg::DATA_W-1:0]     exe_wdata,
	input  wire  [TAG_W-1:0]               exe_tag,
	output logic                           exe_done,
	output logic [mem_pkg::DATA_W-1:0]     exe_rdata,

	// SRAM chip
	output logic [mem_pkg::ADDR_W-1:0]     ram_addr,
	inout  wire  [mem_pkg::DATA_W-1:0]     ram_data,
	output logic                           ram_oe_n,
	output logic                           ram_we_n,
	output logic                           ram_en_n
);

	logic              fetch_need;
	logic              exe_need;
	mem_pkg::mem_req_t fetch_mreq;
	mem_pkg::mem_req_t exe_mreq;
	mem_pkg::mem_rsp_t fetch_rsp;
	mem_pkg::mem_rsp_t exe_rsp;

	// Arbiter to controller
	logic              start;
	logic              busy;
	mem_pkg::mem_req_t grant_req;
	mem_pkg::mem_rsp_t ctrl_rsp;

	fetch_port u_fetch_port (
		.clk        (clk),
		.rst        (rst),
		.fetch_req  (fetch_req),
		.fetch_addr (fetch_addr),
		.fetch_done (fetch_done),
		.fetch_data (fetch_data),
		.need       (fetch_need),
		.req        (fetch_mreq),
		.rsp        (fetch_rsp)
	);

	exe_port #(
		.TAG_W (TAG_W)
	) u_exe_port (
		.clk       (clk),
		.rst       (rst),
		.exe_req   (exe_req),
		.exe_write (exe_write),
		.exe_addr  (exe_addr),
		.exe_wdata (exe_wdata),
		.exe_tag   (exe_tag),
		.exe_done  (exe_done),
		.exe_rdata (exe_rdata),
		.need      (exe_need),
		.req       (exe_mreq),
		.rsp       (exe_rsp)
	);

	ram_arbiter u_ram_arbiter (
		.clk        (clk),
		.rst        (rst),
		.fetch_need (fetch_need),
		.exe_need   (exe_need),
		.fetch_req  (fetch_mreq),
		.exe_req    (exe_mreq),
		.busy       (busy),
		.start      (start),
		.grant_req  (grant_req),
		.ctrl_rsp   (ctrl_rsp),
		.fetch_rsp  (fetch_rsp),
		.exe_rsp    (exe_rsp)
	);

	sram_ctrl #(
		.RAM_WAIT (RAM_WAIT)
	) u_sram_ctrl (
		.clk      (clk),
		.rst      (rst),
		.start    (start),
		.req      (grant_req),
		.busy     (busy),
		.rsp      (ctrl_rsp),
		.ram_addr (ram_addr),
		.ram_data (ram_data),
		.ram_oe_n (ram_oe_n),
		.ram_we_n (ram_we_n),
		.ram_en_n (ram_en_n)
	);

endmodule

`default_nettype wire

// ==== verilog/sram_ctrl.sv ====
`default_nettype none

module sram_ctrl #(
	parameter int RAM_WAIT = 0
) (
	input  wire                            clk,
	input  wire                            rst,

	// From the arbiter
	input  wire                            start,
	input  mem_pkg::mem_req_t              req,
	output logic                           busy,
	output mem_pkg::mem_rsp_t              rsp,

	// SRAM pins
	output logic [mem_pkg::ADDR_W-1:0]     ram_addr,
	inout  wire  [mem_pkg::DATA_W-1:0]     ram_data,
	output logic                           ram_oe_n,
	output logic                           ram_we_n,
	output logic                           ram_en_n
);

	// Counter wide enough for the last strobe index
	localparam int CNT_W = (RAM_WAIT > 0) ? $clog2(RAM_WAIT + 1) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RAM_WAIT);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_SETUP,
		ST_STROBE,
		ST_FINISH
	} state_t;

	state_t                     state;
	logic [CNT_W-1:0]           cnt;
	logic                       drive;
	logic                       done_q;

	// Access held for the whole sequence
	logic                       write_q;
	logic [mem_pkg::ADDR_W-1:0] addr_q;
	logic [mem_pkg::DATA_W-1:0] wdata_q;
	logic [mem_pkg::DATA_W-1:0] rdata_q;

	////////////////////
	// Pins and status
	////////////////////

	assign ram_addr  = addr_q;
	assign ram_data  = drive ? wdata_q : 'z;
	assign busy      = (state != ST_IDLE);
	assign rsp.done  = done_q;
	assign rsp.rdata = rdata_q;

	////////////////////
	// Strobe sequencer
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			state    <= ST_IDLE;
			cnt      <= '0;
			drive    <= 1'b0;
			done_q   <= 1'b0;
			ram_oe_n <= 1'b1;
			ram_we_n <= 1'b1;
			ram_en_n <= 1'b1;
		end else begin
			case (state)
				ST_IDLE: begin
					if (start) begin
						state    <= ST_SETUP;
						ram_en_n <= 1'b0;
						// Writes put data on the bus ahead of we_n
						drive    <= req.write;
					end
				end

				ST_SETUP: begin
					state <= ST_STROBE;
					cnt   <= '0;
					if (write_q) begin
						ram_we_n <= 1'b0;
					end else begin
						ram_oe_n <= 1'b0;
					end
				end

				ST_STROBE: begin
					if (cnt == CNT_LAST) begin
						state    <= ST_FINISH;
						ram_oe_n <= 1'b1;
						ram_we_n <= 1'b1;
						done_q   <= 1'b1;
					end else begin
						cnt <= cnt + 1'b1;
					end
				end

				ST_FINISH: begin
					// Data still held here so the write hold time is met
					state    <= ST_IDLE;
					done_q   <= 1'b0;
					drive    <= 1'b0;
					ram_en_n <= 1'b1;
				end

				default: state <= ST_IDLE;
			endcase
		end
	end

	// Latch the access on start
	always_ff @(posedge clk) begin
		if (state == ST_IDLE && start) begin
			write_q <= req.write;
			addr_q  <= req.addr;
			wdata_q <= req.wdata;
		end
	end

	// Read data taken while oe_n is still low
	always_ff @(posedge clk) begin
		if (state == ST_STROBE && cnt == CNT_LAST && !write_q) begin
			rdata_q <= ram_data;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/ram_arbiter.sv ====
`default_nettype none

module ram_arbiter (
	input  wire                  clk,
	input  wire                  rst,

	// Requesters
	input  wire                  fetch_need,
	input  wire                  exe_need,
	input  mem_pkg::mem_req_t    fetch_req,
	input  mem_pkg::mem_req_t    exe_req,

	// Controller
	input  wire                  busy,
	output logic                 start,
	output mem_pkg::mem_req_t    grant_req,
	input  mem_pkg::mem_rsp_t    ctrl_rsp,

	// Completions back to the requesters
	output mem_pkg::mem_rsp_t    fetch_rsp,
	output mem_pkg::mem_rsp_t    exe_rsp
);

	mem_pkg::req_src_t owner;
	logic              free;

	// Controller takes start one cycle late, so block the start cycle too
	assign free = !busy && !start;

	////////////////////
	// Grant
	////////////////////

	// Execute first, fetch only when no load or store waits
	always_ff @(posedge clk) begin
		if (!rst) begin
			start <= 1'b0;
			owner <= mem_pkg::SRC_FETCH;
		end else begin
			start <= 1'b0;
			if (free && exe_need) begin
				start <= 1'b1;
				owner <= mem_pkg::SRC_EXE;
			end else if (free && fetch_need) begin
				start <= 1'b1;
				owner <= mem_pkg::SRC_FETCH;
			end
		end
	end

	// Granted request, held steady for the controller
	always_ff @(posedge clk) begin
		if (free) begin
			grant_req <= exe_need ? exe_req : fetch_req;
		end
	end

	////////////////////
	// Completion steering
	////////////////////

	assign fetch_rsp.done  = ctrl_rsp.done && (owner == mem_pkg::SRC_FETCH);
	assign fetch_rsp.rdata = ctrl_rsp.rdata;
	assign exe_rsp.done    = ctrl_rsp.done && (owner == mem_pkg::SRC_EXE);
	assign exe_rsp.rdata   = ctrl_rsp.rdata;

endmodule

`default_nettype wire

// ==== verilog/exe_port.sv ====
`default_nettype none

module exe_port #(
	parameter int TAG_W = 8
) (
	input  wire                            clk,
	input  wire                            rst,

	// Load/store side
	input  wire                            exe_req,
	input  wire                            exe_write,
	input  wire  [mem_pkg::ADDR_W-1:0]     exe_addr,
	input  wire  [mem_pkg::DATA_W-1:0]     exe_wdata,
	input  wire  [TAG_W-1:0]               exe_tag,
	output logic                           exe_done,
	output logic [mem_pkg::DATA_W-1:0]     exe_rdata,

	// Arbiter side
	output logic                           need,
	output mem_pkg::mem_req_t              req,
	input  mem_pkg::mem_rsp_t              rsp
);

	// Tag of the last access that finished
	logic [TAG_W-1:0] done_tag;

	////////////////////
	// Request side
	////////////////////

	// A changed tag marks a new load or store
	assign need = exe_req && (exe_tag != done_tag);

	assign req = '{write: exe_write, addr: exe_addr, wdata: exe_wdata};

	// Level, stays up until the next tag change
	assign exe_done = (exe_tag == done_tag);

	////////////////////
	// Completion
	////////////////////

	always_ff @(posedge clk) begin
		if (!rst) begin
			done_tag <= '0;
		end else if (rsp.done) begin
			done_tag <= exe_tag;
		end
	end

	// Load result, kept across stores
	always_ff @(posedge clk) begin
		if (rsp.done && !exe_write) begin
			exe_rdata <= rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/fetch_port.sv ====
`default_nettype none

module fetch_port (
	input  wire                            clk,
	input  wire                            rst,

	// Program side
	input  wire                            fetch_req,
	input  wire  [mem_pkg::ADDR_W-1:0]     fetch_addr,
	output logic                           fetch_done,
	output logic [mem_pkg::DATA_W-1:0]     fetch_data,

	// Arbiter side
	output logic                           need,
	output mem_pkg::mem_req_t              req,
	input  mem_pkg::mem_rsp_t              rsp
);

	// Address of the word held in fetch_data
	logic [mem_pkg::ADDR_W-1:0] last_pc;

	////////////////////
	// Request side
	////////////////////

	// Only a new address costs an SRAM read
	assign need = fetch_req && (fetch_addr != last_pc);

	// Instruction fetch never writes
	assign req = '{write: 1'b0, addr: fetch_addr, wdata: '0};

	// Word is ready as soon as the address matches the remembered one
	assign fetch_done = (fetch_addr == last_pc);

	////////////////////
	// Completion
	////////////////////

	// All ones never matches a fresh program counter of zero
	always_ff @(posedge clk) begin
		if (!rst) begin
			last_pc <= '1;
		end else if (rsp.done) begin
			last_pc <= fetch_addr;
		end
	end

	// Fetched word
	always_ff @(posedge clk) begin
		if (rsp.done) begin
			fetch_data <= rsp.rdata;
		end
	end

endmodule

`default_nettype wire

// ==== verilog/mem_pkg.sv ====
`default_nettype none

package mem_pkg;

	////////////////////
	// Widths
	////////////////////

	// One SRAM word per address
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;

	////////////////////
	// Controller request and completion
	////////////////////

	// One access handed to the strobe sequencer
	typedef struct packed {
		logic              write;
		logic [ADDR_W-1:0] addr;
		logic [DATA_W-1:0] wdata;
	} mem_req_t;

	// Done is a single-cycle pulse, rdata valid with it on reads
	typedef struct packed {
		logic              done;
		logic [DATA_W-1:0] rdata;
	} mem_rsp_t;

	////////////////////
	// Grant owner
	////////////////////

	typedef enum logic [0:0] {
		SRC_FETCH = 1'b0,
		SRC_EXE   = 1'b1
	} req_src_t;

endpackage

`default_nettype wire
